// ==== source/glb_cfg_pkg.sv ====
/*
 * Widths and word types shared by the SRAM configuration path.
 * Address layout from high to low is tile field, bank field, word field.
 * BANKS_PER_TILE is derived from BANK_SEL_ADDR_WIDTH and is not set alone.
 * NUM_TILES at the top must not exceed 2**TILE_SEL_ADDR_WIDTH.
 */
package glb_cfg_pkg;

    // tile field width, also caps the tile count
    localparam int TILE_SEL_ADDR_WIDTH = 3;

    // bank field width inside a tile
    localparam int BANK_SEL_ADDR_WIDTH = 1;

    // banks per tile follow the bank field
    localparam int BANKS_PER_TILE = 2 ** BANK_SEL_ADDR_WIDTH;

    // word index inside one bank
    localparam int BANK_ADDR_WIDTH = 6;

    // one configuration word
    localparam int BANK_DATA_WIDTH = 32;

    // full host address
    localparam int CFG_ADDR_WIDTH = TILE_SEL_ADDR_WIDTH + BANK_SEL_ADDR_WIDTH
                                    + BANK_ADDR_WIDTH;

    typedef logic [CFG_ADDR_WIDTH-1:0]  cfg_addr_t;
    typedef logic [BANK_DATA_WIDTH-1:0] cfg_data_t;
    typedef logic [BANK_ADDR_WIDTH-1:0] bank_addr_t;

endpackage

// ==== source/glb_bank_sram.sv ====
/*
 * One configuration SRAM bank with a single write and a single read port.
 * Read data and its valid strobe appear one cycle after the read request.
 * The array has no reset, so unwritten words read back as unknown.
 * A write and a read to the same word in one cycle have no defined order.
 */
`timescale 1ns/1ps

module glb_bank_sram (
    input  logic                    clk,
    input  logic                    reset,

    // write request from the controller
    input  logic                    wr_en,
    input  logic                    wr_clk_en,
    input  glb_cfg_pkg::bank_addr_t wr_addr,
    input  glb_cfg_pkg::cfg_data_t  wr_data,

    // read request from the controller
    input  logic                    rd_en,
    input  logic                    rd_clk_en,
    input  glb_cfg_pkg::bank_addr_t rd_addr,

    // read response back to the controller
    output glb_cfg_pkg::cfg_data_t  rd_data,
    output logic                    rd_data_valid
);

    localparam int DEPTH = 2 ** glb_cfg_pkg::BANK_ADDR_WIDTH;

    // storage array
    glb_cfg_pkg::cfg_data_t mem [DEPTH];

    logic wr_fire;
    logic rd_fire;

    // both enables needed for an access
    assign wr_fire = wr_en && wr_clk_en;
    assign rd_fire = rd_en && rd_clk_en;

    // write on the edge that sees the request
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read word registered, holds between reads
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rd_data <= mem[rd_addr];
        end
    end

    // strobe marks the single cycle of valid read data
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_data_valid <= 1'b0;
        end else begin
            rd_data_valid <= rd_fire;
        end
    end

    // same word written and read in one cycle
    a_no_wr_rd_collision: assert property (
        @(posedge clk) disable iff (reset)
        !(wr_fire && rd_fire && (wr_addr == rd_addr))
    ) else $error("bank write and read hit word %0d in the same cycle", wr_addr);

endmodule

// ==== source/glb_tile_sram_cfg_ctrl.sv ====
/*
 * Per-tile configuration controller.
 * Decodes west requests against TILE_ID and steers them to one local bank.
 * Every request goes east through one register, whether it matched or not.
 * Read data returns west through one register with no arbitration, so the
 * host must keep a single read outstanding.
 */
`timescale 1ns/1ps

module glb_tile_sram_cfg_ctrl #(
    parameter int TILE_ID = 0
) (
    input  logic                    clk,
    input  logic                    reset,

    // west request in
    input  logic                    wst_wr_en,
    input  logic                    wst_wr_clk_en,
    input  glb_cfg_pkg::cfg_addr_t  wst_wr_addr,
    input  glb_cfg_pkg::cfg_data_t  wst_wr_data,
    input  logic                    wst_rd_en,
    input  logic                    wst_rd_clk_en,
    input  glb_cfg_pkg::cfg_addr_t  wst_rd_addr,

    // west response out
    output glb_cfg_pkg::cfg_data_t  wst_rd_data,
    output logic                    wst_rd_data_valid,

    // east request out
    output logic                    est_wr_en,
    output logic                    est_wr_clk_en,
    output glb_cfg_pkg::cfg_addr_t  est_wr_addr,
    output glb_cfg_pkg::cfg_data_t  est_wr_data,
    output logic                    est_rd_en,
    output logic                    est_rd_clk_en,
    output glb_cfg_pkg::cfg_addr_t  est_rd_addr,

    // east response in
    input  glb_cfg_pkg::cfg_data_t  est_rd_data,
    input  logic                    est_rd_data_valid,

    // local bank links
    output logic                    bank_wr_en     [glb_cfg_pkg::BANKS_PER_TILE],
    output logic                    bank_wr_clk_en [glb_cfg_pkg::BANKS_PER_TILE],
    output glb_cfg_pkg::bank_addr_t bank_wr_addr   [glb_cfg_pkg::BANKS_PER_TILE],
    output glb_cfg_pkg::cfg_data_t  bank_wr_data   [glb_cfg_pkg::BANKS_PER_TILE],
    output logic                    bank_rd_en     [glb_cfg_pkg::BANKS_PER_TILE],
    output logic                    bank_rd_clk_en [glb_cfg_pkg::BANKS_PER_TILE],
    output glb_cfg_pkg::bank_addr_t bank_rd_addr   [glb_cfg_pkg::BANKS_PER_TILE],
    input  glb_cfg_pkg::cfg_data_t  bank_rd_data   [glb_cfg_pkg::BANKS_PER_TILE],
    input  logic                    bank_rd_data_valid [glb_cfg_pkg::BANKS_PER_TILE]
);

    localparam int NB  = glb_cfg_pkg::BANKS_PER_TILE;
    localparam int BAW = glb_cfg_pkg::BANK_ADDR_WIDTH;
    localparam int BSW = glb_cfg_pkg::BANK_SEL_ADDR_WIDTH;
    localparam int TSW = glb_cfg_pkg::TILE_SEL_ADDR_WIDTH;

    // field offsets inside the host address
    localparam int BANK_SEL_LSB = BAW;
    localparam int TILE_SEL_LSB = BAW + BSW;

    localparam logic [TSW-1:0] TILE_SEL = TSW'(TILE_ID);

    logic                   wr_tile_hit;
    logic                   rd_tile_hit;
    logic [NB-1:0]          bank_valid_vec;
    logic                   local_rd_valid;
    glb_cfg_pkg::cfg_data_t local_rd_data;

    // tile field compare, purely combinational
    assign wr_tile_hit = (wst_wr_addr[TILE_SEL_LSB +: TSW] == TILE_SEL);
    assign rd_tile_hit = (wst_rd_addr[TILE_SEL_LSB +: TSW] == TILE_SEL);

    for (genvar i = 0; i < NB; i++) begin : g_bank
        localparam logic [BSW-1:0] BANK_SEL = BSW'(i);

        logic wr_hit;
        logic rd_hit;

        assign wr_hit = wr_tile_hit && (wst_wr_addr[BANK_SEL_LSB +: BSW] == BANK_SEL);
        assign rd_hit = rd_tile_hit && (wst_rd_addr[BANK_SEL_LSB +: BSW] == BANK_SEL);

        // only the selected bank sees enables
        assign bank_wr_en[i]     = wst_wr_en && wr_hit;
        assign bank_wr_clk_en[i] = wst_wr_clk_en && wr_hit;
        assign bank_rd_en[i]     = wst_rd_en && rd_hit;
        assign bank_rd_clk_en[i] = wst_rd_clk_en && rd_hit;

        // address and data fan out to all banks
        assign bank_wr_addr[i] = wst_wr_addr[0 +: BAW];
        assign bank_wr_data[i] = wst_wr_data;
        assign bank_rd_addr[i] = wst_rd_addr[0 +: BAW];

        assign bank_valid_vec[i] = bank_rd_data_valid[i];
    end

    // pick the local bank that answered
    always_comb begin
        local_rd_valid = 1'b0;
        local_rd_data  = '0;
        for (int b = 0; b < NB; b++) begin
            if (bank_rd_data_valid[b]) begin
                local_rd_valid = 1'b1;
                local_rd_data  = bank_rd_data[b];
            end
        end
    end

    // east forward and west return registers
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            est_wr_en         <= 1'b0;
            est_wr_clk_en     <= 1'b0;
            est_wr_addr       <= '0;
            est_wr_data       <= '0;
            est_rd_en         <= 1'b0;
            est_rd_clk_en     <= 1'b0;
            est_rd_addr       <= '0;
            wst_rd_data       <= '0;
            wst_rd_data_valid <= 1'b0;
        end else begin
            // request passes east unchanged
            est_wr_en     <= wst_wr_en;
            est_wr_clk_en <= wst_wr_clk_en;
            est_wr_addr   <= wst_wr_addr;
            est_wr_data   <= wst_wr_data;
            est_rd_en     <= wst_rd_en;
            est_rd_clk_en <= wst_rd_clk_en;
            est_rd_addr   <= wst_rd_addr;
            // local answer wins, east otherwise
            wst_rd_data_valid <= local_rd_valid || est_rd_data_valid;
            wst_rd_data       <= local_rd_valid ? local_rd_data : est_rd_data;
        end
    end

    // one bank answers per cycle
    a_one_local_valid: assert property (
        @(posedge clk) disable iff (reset) $onehot0(bank_valid_vec)
    ) else $error("tile %0d: more than one bank returned read data", TILE_ID);

    // one outstanding read keeps local and east returns apart
    a_no_return_collision: assert property (
        @(posedge clk) disable iff (reset) !(local_rd_valid && est_rd_data_valid)
    ) else $error("tile %0d: local and east read data valid together", TILE_ID);

endmodule

// ==== source/glb_tile.sv ====
/*
 * One global buffer tile, a configuration controller with its SRAM banks.
 * Requests enter on the west side and leave east one cycle later.
 * Read data leaves west one cycle after it reaches the controller.
 */
`timescale 1ns/1ps

module glb_tile #(
    parameter int TILE_ID = 0
) (
    input  logic                   clk,
    input  logic                   reset,

    // west request in
    input  logic                   wst_wr_en,
    input  logic                   wst_wr_clk_en,
    input  glb_cfg_pkg::cfg_addr_t wst_wr_addr,
    input  glb_cfg_pkg::cfg_data_t wst_wr_data,
    input  logic                   wst_rd_en,
    input  logic                   wst_rd_clk_en,
    input  glb_cfg_pkg::cfg_addr_t wst_rd_addr,

    // west response out
    output glb_cfg_pkg::cfg_data_t wst_rd_data,
    output logic                   wst_rd_data_valid,

    // east request out
    output logic                   est_wr_en,
    output logic                   est_wr_clk_en,
    output glb_cfg_pkg::cfg_addr_t est_wr_addr,
    output glb_cfg_pkg::cfg_data_t est_wr_data,
    output logic                   est_rd_en,
    output logic                   est_rd_clk_en,
    output glb_cfg_pkg::cfg_addr_t est_rd_addr,

    // east response in
    input  glb_cfg_pkg::cfg_data_t est_rd_data,
    input  logic                   est_rd_data_valid
);

    localparam int NB = glb_cfg_pkg::BANKS_PER_TILE;

    // controller to bank links
    logic                    bank_wr_en         [NB];
    logic                    bank_wr_clk_en     [NB];
    glb_cfg_pkg::bank_addr_t bank_wr_addr       [NB];
    glb_cfg_pkg::cfg_data_t  bank_wr_data       [NB];
    logic                    bank_rd_en         [NB];
    logic                    bank_rd_clk_en     [NB];
    glb_cfg_pkg::bank_addr_t bank_rd_addr       [NB];
    glb_cfg_pkg::cfg_data_t  bank_rd_data       [NB];
    logic                    bank_rd_data_valid [NB];

    glb_tile_sram_cfg_ctrl #(
        .TILE_ID (TILE_ID)
    ) ctrl_i (
        .*
    );

    // one bank per bank field value
    for (genvar i = 0; i < NB; i++) begin : g_bank
        glb_bank_sram bank_i (
            .clk           (clk),
            .reset         (reset),
            .wr_en         (bank_wr_en[i]),
            .wr_clk_en     (bank_wr_clk_en[i]),
            .wr_addr       (bank_wr_addr[i]),
            .wr_data       (bank_wr_data[i]),
            .rd_en         (bank_rd_en[i]),
            .rd_clk_en     (bank_rd_clk_en[i]),
            .rd_addr       (bank_rd_addr[i]),
            .rd_data       (bank_rd_data[i]),
            .rd_data_valid (bank_rd_data_valid[i])
        );
    end

endmodule

// ==== source/glb_cfg_top.sv ====
/*
 * Chain of NUM_TILES tiles with the host port on the west of tile 0.
 * NUM_TILES must not exceed 2**TILE_SEL_ADDR_WIDTH.
 * A read to tile k returns 2k+2 cycles after issue. Keep one read in flight.
 * Requests to a missing tile run off the east end and never answer.
 */
`timescale 1ns/1ps

module glb_cfg_top #(
    parameter int NUM_TILES = 4
) (
    input  logic                   clk,
    input  logic                   reset,

    // host request
    input  logic                   wr_en,
    input  logic                   wr_clk_en,
    input  glb_cfg_pkg::cfg_addr_t wr_addr,
    input  glb_cfg_pkg::cfg_data_t wr_data,
    input  logic                   rd_en,
    input  logic                   rd_clk_en,
    input  glb_cfg_pkg::cfg_addr_t rd_addr,

    // host response
    output glb_cfg_pkg::cfg_data_t rd_data,
    output logic                   rd_data_valid
);

    // hop k feeds the west side of tile k
    // last entry is the east end, left open for requests
    logic                   req_wr_en     [NUM_TILES+1];
    logic                   req_wr_clk_en [NUM_TILES+1];
    glb_cfg_pkg::cfg_addr_t req_wr_addr   [NUM_TILES+1];
    glb_cfg_pkg::cfg_data_t req_wr_data   [NUM_TILES+1];
    logic                   req_rd_en     [NUM_TILES+1];
    logic                   req_rd_clk_en [NUM_TILES+1];
    glb_cfg_pkg::cfg_addr_t req_rd_addr   [NUM_TILES+1];
    glb_cfg_pkg::cfg_data_t rsp_data      [NUM_TILES+1];
    logic                   rsp_valid     [NUM_TILES+1];

    // host enters at hop 0
    assign req_wr_en[0]     = wr_en;
    assign req_wr_clk_en[0] = wr_clk_en;
    assign req_wr_addr[0]   = wr_addr;
    assign req_wr_data[0]   = wr_data;
    assign req_rd_en[0]     = rd_en;
    assign req_rd_clk_en[0] = rd_clk_en;
    assign req_rd_addr[0]   = rd_addr;
    assign rd_data          = rsp_data[0];
    assign rd_data_valid    = rsp_valid[0];

    // nothing answers beyond the last tile
    assign rsp_data[NUM_TILES]  = '0;
    assign rsp_valid[NUM_TILES] = 1'b0;

    for (genvar k = 0; k < NUM_TILES; k++) begin : g_tile
        glb_tile #(
            .TILE_ID (k)
        ) tile_i (
            .clk               (clk),
            .reset             (reset),
            .wst_wr_en         (req_wr_en[k]),
            .wst_wr_clk_en     (req_wr_clk_en[k]),
            .wst_wr_addr       (req_wr_addr[k]),
            .wst_wr_data       (req_wr_data[k]),
            .wst_rd_en         (req_rd_en[k]),
            .wst_rd_clk_en     (req_rd_clk_en[k]),
            .wst_rd_addr       (req_rd_addr[k]),
            .wst_rd_data       (rsp_data[k]),
            .wst_rd_data_valid (rsp_valid[k]),
            .est_wr_en         (req_wr_en[k+1]),
            .est_wr_clk_en     (req_wr_clk_en[k+1]),
            .est_wr_addr       (req_wr_addr[k+1]),
            .est_wr_data       (req_wr_data[k+1]),
            .est_rd_en         (req_rd_en[k+1]),
            .est_rd_clk_en     (req_rd_clk_en[k+1]),
            .est_rd_addr       (req_rd_addr[k+1]),
            .est_rd_data       (rsp_data[k+1]),
            .est_rd_data_valid (rsp_valid[k+1])
        );
    end

endmodule

// ==== tb/glb_cfg_tb.sv ====
/*
 * Testbench for the tiled SRAM configuration path, four tiles.
 * Keeps one read in flight, as the controller return path requires.
 * Reads only words that were written, since the bank array has no reset.
 * Latency is counted in clock edges from the edge that samples the read.
 */
`timescale 1ns/1ps

module glb_cfg_tb;

    localparam int NUM_TILES   = 4;
    localparam int NB          = glb_cfg_pkg::BANKS_PER_TILE;
    localparam int BAW         = glb_cfg_pkg::BANK_ADDR_WIDTH;
    localparam int BSW         = glb_cfg_pkg::BANK_SEL_ADDR_WIDTH;
    localparam int TSW         = glb_cfg_pkg::TILE_SEL_ADDR_WIDTH;
    localparam int ADDR_SPACE  = 2 ** glb_cfg_pkg::CFG_ADDR_WIDTH;
    localparam int WORDS_EACH  = 4;
    localparam int DIRECTED    = NUM_TILES * NB * WORDS_EACH;
    localparam int NUM_RAND    = 64;
    localparam int WORST_LAT   = 2 * NUM_TILES + 2;
    // every write, every read and a few idle checks
    localparam int OP_COUNT    = 3 * DIRECTED + 2 * NUM_RAND + 16;
    localparam int CYCLE_LIMIT = OP_COUNT * (WORST_LAT + 4) + 500;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   wr_en;
    logic                   wr_clk_en;
    glb_cfg_pkg::cfg_addr_t wr_addr;
    glb_cfg_pkg::cfg_data_t wr_data;
    logic                   rd_en;
    logic                   rd_clk_en;
    glb_cfg_pkg::cfg_addr_t rd_addr;
    glb_cfg_pkg::cfg_data_t rd_data;
    logic                   rd_data_valid;

    integer seed;
    int     cycle;
    int     data_errors;
    int     latency_errors;
    int     protocol_errors;

    // shadow of the whole address space
    glb_cfg_pkg::cfg_data_t shadow [ADDR_SPACE];
    glb_cfg_pkg::cfg_addr_t rand_addr [NUM_RAND];

    // reads waiting for their return
    glb_cfg_pkg::cfg_data_t pend_data [$];
    glb_cfg_pkg::cfg_addr_t pend_addr [$];
    int                     pend_edge [$];

    glb_cfg_top #(
        .NUM_TILES (NUM_TILES)
    ) dut_i (
        .clk           (clk),
        .reset         (reset),
        .wr_en         (wr_en),
        .wr_clk_en     (wr_clk_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .rd_en         (rd_en),
        .rd_clk_en     (rd_clk_en),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .rd_data_valid (rd_data_valid)
    );

    always #10 clk = ~clk;

    // edge counter, also the run limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    always @(posedge clk) begin
        if (cycle >= CYCLE_LIMIT) begin
            $display("simulation ran past %0d cycles and was stopped", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // tile field high, word field low
    function automatic glb_cfg_pkg::cfg_addr_t make_addr(input int tile, input int bank,
                                                         input int word);
        return (glb_cfg_pkg::cfg_addr_t'(tile) << (BSW + BAW))
             | (glb_cfg_pkg::cfg_addr_t'(bank) << BAW)
             | glb_cfg_pkg::cfg_addr_t'(word);
    endfunction

    // expected word from the shadow, tile from the top field
    function automatic glb_cfg_pkg::cfg_data_t expected_word(input glb_cfg_pkg::cfg_addr_t addr,
                                                             output int tile);
        tile = int'(addr >> (BSW + BAW));
        return shadow[addr];
    endfunction

    task automatic check_data(input glb_cfg_pkg::cfg_data_t got,
                              input glb_cfg_pkg::cfg_data_t want,
                              input glb_cfg_pkg::cfg_addr_t addr);
        if (got !== want) begin
            $display("Error at %0t: read data at address 0x%0h is 0x%08h, expected 0x%08h",
                     $time, addr, got, want);
            data_errors++;
        end
    endtask

    task automatic check_latency(input int got_edge, input int want_edge,
                                 input glb_cfg_pkg::cfg_addr_t addr);
        if (got_edge != want_edge) begin
            $display("Error at %0t: read of address 0x%0h returned at edge %0d, expected %0d",
                     $time, addr, got_edge, want_edge);
            latency_errors++;
        end
    endtask

    task automatic pick_random(input int range, output int value);
        value = int'({$random(seed)} % range);
    endtask

    // one write per call, back to back when called in a row
    task automatic drive_write(input glb_cfg_pkg::cfg_addr_t addr,
                               input glb_cfg_pkg::cfg_data_t data, input logic clk_en);
        @(negedge clk);
        wr_en     = 1'b1;
        wr_clk_en = clk_en;
        wr_addr   = addr;
        wr_data   = data;
        if (clk_en) begin
            shadow[addr] = data;
        end
    endtask

    task automatic release_bus();
        @(negedge clk);
        wr_en     = 1'b0;
        wr_clk_en = 1'b0;
        rd_en     = 1'b0;
        rd_clk_en = 1'b0;
    endtask

    // issue one read, then wait for its return or a quiet window
    task automatic issue_read(input glb_cfg_pkg::cfg_addr_t addr, input logic clk_en,
                              input logic expect_rsp);
        int                     tile;
        int                     waited;
        glb_cfg_pkg::cfg_data_t want;
        @(negedge clk);
        wr_en     = 1'b0;
        wr_clk_en = 1'b0;
        rd_en     = 1'b1;
        rd_clk_en = clk_en;
        rd_addr   = addr;
        if (expect_rsp) begin
            want = expected_word(addr, tile);
            pend_data.push_back(want);
            pend_addr.push_back(addr);
            // sampled at edge cycle+1, back 2k+2 edges later
            pend_edge.push_back(cycle + 1 + 2 * tile + 2);
        end
        @(negedge clk);
        rd_en     = 1'b0;
        rd_clk_en = 1'b0;
        if (expect_rsp) begin
            waited = 0;
            while (pend_data.size() != 0 && waited < WORST_LAT + 4) begin
                @(negedge clk);
                waited++;
            end
            if (pend_data.size() != 0) begin
                $display("read of address 0x%0h to tile %0d never returned data", addr, tile);
                protocol_errors++;
                pend_data.delete();
                pend_addr.delete();
                pend_edge.delete();
            end
        end else begin
            repeat (2 * NUM_TILES + 4) @(negedge clk);
        end
    endtask

    // compare every return against the oldest pending read
    always @(posedge clk) begin : compare_returns
        glb_cfg_pkg::cfg_data_t want_data;
        glb_cfg_pkg::cfg_addr_t want_addr;
        int                     want_edge;
        if (!reset && rd_data_valid === 1'b1) begin
            if (pend_data.size() == 0) begin
                $display("read data came back at time %0t while no read was pending", $time);
                protocol_errors++;
            end else begin
                want_data = pend_data.pop_front();
                want_addr = pend_addr.pop_front();
                want_edge = pend_edge.pop_front();
                check_data(rd_data, want_data, want_addr);
                check_latency(cycle + 1, want_edge, want_addr);
            end
        end
    end

    initial begin
        int                     t;
        int                     b;
        int                     w;
        int                     i;
        glb_cfg_pkg::cfg_addr_t a;
        seed            = 32'h6c74_d99d;
        cycle           = 0;
        data_errors     = 0;
        latency_errors  = 0;
        protocol_errors = 0;
        reset           = 1'b1;
        wr_en           = 1'b0;
        wr_clk_en       = 1'b0;
        wr_addr         = '0;
        wr_data         = '0;
        rd_en           = 1'b0;
        rd_clk_en       = 1'b0;
        rd_addr         = '0;
        repeat (8) @(negedge clk);
        reset = 1'b0;

        // quiet bus after reset
        repeat (10) begin
            @(negedge clk);
            if (rd_data_valid !== 1'b0) begin
                $display("rd_data_valid was not low after reset with no read issued");
                protocol_errors++;
            end
        end

        // every bank of every tile, write then read
        for (t = 0; t < NUM_TILES; t++)
            for (b = 0; b < NB; b++)
                for (w = 0; w < WORDS_EACH; w++)
                    drive_write(make_addr(t, b, w), glb_cfg_pkg::cfg_data_t'($random(seed)), 1'b1);
        release_bus();
        for (t = 0; t < NUM_TILES; t++)
            for (b = 0; b < NB; b++)
                for (w = 0; w < WORDS_EACH; w++)
                    issue_read(make_addr(t, b, w), 1'b1, 1'b1);

        // streaming random writes, small word range so some overwrite
        for (i = 0; i < NUM_RAND; i++) begin
            pick_random(NUM_TILES, t);
            pick_random(NB, b);
            pick_random(16, w);
            rand_addr[i] = make_addr(t, b, w);
            drive_write(rand_addr[i], glb_cfg_pkg::cfg_data_t'($random(seed)), 1'b1);
        end
        release_bus();
        for (i = 0; i < NUM_RAND; i++)
            issue_read(rand_addr[i], 1'b1, 1'b1);
        // untouched words must keep their values
        for (t = 0; t < NUM_TILES; t++)
            for (b = 0; b < NB; b++)
                for (w = 0; w < WORDS_EACH; w++)
                    issue_read(make_addr(t, b, w), 1'b1, 1'b1);

        // clock enables low, no effect
        for (t = 0; t < NUM_TILES; t++) begin
            a = make_addr(t, t % NB, 2);
            drive_write(a, ~shadow[a], 1'b0);
            release_bus();
            issue_read(a, 1'b0, 1'b0);
            issue_read(a, 1'b1, 1'b1);
        end

        // tile fields past the last tile never answer
        for (t = NUM_TILES; t < 2 ** TSW; t++)
            issue_read(make_addr(t, 0, t), 1'b1, 1'b0);

        release_bus();
        repeat (WORST_LAT) @(negedge clk);
        $display("data errors %0d, latency errors %0d, protocol errors %0d",
                 data_errors, latency_errors, protocol_errors);
        if (data_errors == 0 && latency_errors == 0 && protocol_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== files.f ====
source/glb_cfg_pkg.sv
source/glb_bank_sram.sv
source/glb_tile_sram_cfg_ctrl.sv
source/glb_tile.sv
source/glb_cfg_top.sv
tb/glb_cfg_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module glb_cfg_tb -f files.f \
    || { echo "build failed"; exit 1; }
sim_out=$(./obj_dir/Vglb_cfg_tb 2>&1)
echo "$sim_out"
echo "$sim_out" | grep -q "RESULT: PASS" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
